//--- src/act_pkg.sv
package act_pkg;

  // ##########################################################
  // lane and code formats
  // ##########################################################

  localparam int DATA_W   = 8;  // one lane value, signed q4.4
  localparam int FRAC_W   = 4;  // fraction bits of input and output
  localparam int SIG_W    = 9;  // sigmoid code, unsigned q1.8
  localparam int SIG_FRAC = 8;

  localparam int LANES    = 2;  // values per beat
  localparam int LUT_SIZE = 2 ** DATA_W;

  localparam int LANE_MAX = 2 ** (DATA_W - 1) - 1;
  localparam int LANE_MIN = -(2 ** (DATA_W - 1));

  // ##########################################################
  // datapath constants
  // ##########################################################

  localparam int LEAKY_SHIFT = 3;  // leaky slope of 1/8

  localparam int PROD_W    = DATA_W + SIG_W + 1;  // signed x times zero-extended code
  localparam int SILU_RND  = 2 ** (SIG_FRAC - 1);  // half lsb before the q1.8 drop
  localparam int SIG_SHIFT = SIG_FRAC - FRAC_W;  // q1.8 code down to q4.4
  localparam int SIG_RND   = 2 ** (SIG_SHIFT - 1);

  // input buffering
  localparam int FIFO_DEPTH = 4;
  localparam int PTR_W      = $clog2(FIFO_DEPTH);
  localparam int CNT_W      = $clog2(FIFO_DEPTH + 1);

  typedef enum logic [1:0] {
    OP_SILU    = 2'd0,
    OP_SIGMOID = 2'd1,
    OP_RELU    = 2'd2,
    OP_LEAKY   = 2'd3
  } act_op_e;

  typedef logic signed [DATA_W-1:0] lane_t;
  typedef logic [SIG_W-1:0] sig_t;

endpackage

//--- src/act_stream_if.sv
`timescale 1ns/1ps

interface act_stream_if import act_pkg::*; ();

  lane_t [LANES-1:0] lanes;  // one beat, lane 0 in the low bits
  act_op_e           op;
  logic              valid;
  logic              ready;

  // producer side, the fifo read port
  modport src (
    output lanes,
    output op,
    output valid,
    input  ready
  );

  // consumer that pops the beat
  modport snk (
    input  lanes,
    input  op,
    input  valid,
    output ready
  );

  // side paths that only look at the beat
  modport tap (
    input lanes,
    input op
  );

endinterface

//--- src/beat_fifo.sv
`timescale 1ns/1ps

module beat_fifo import act_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  lane_t [LANES-1:0] in_lanes,
  input  act_op_e           in_op,
  input  logic              in_valid,
  output logic              in_ready,
  act_stream_if.src         out
);

  lane_t [LANES-1:0] lanes_mem [FIFO_DEPTH];
  act_op_e           op_mem [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;  // beats held
  logic             full;
  logic             wr_en;
  logic             rd_en;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full      = (count == CNT_W'(FIFO_DEPTH));
  assign in_ready  = !full;
  assign wr_en     = in_valid && in_ready;
  assign rd_en     = out.valid && out.ready;

  assign out.valid = (count != '0);
  assign out.lanes = lanes_mem[rd_ptr];  // head of queue
  assign out.op    = op_mem[rd_ptr];

  // ##########################################################
  // storage and pointers
  // ##########################################################

  always_ff @(posedge clk) begin
    if (wr_en) begin
      lanes_mem[wr_ptr] <= in_lanes;
      op_mem[wr_ptr]    <= in_op;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // idle or push and pop together
      endcase
    end
  end

  // a write into a non-empty buffer never lands on the unread head
  a_no_overwrite: assert property (@(posedge clk) disable iff (reset)
    wr_en && (count != '0) |-> wr_ptr != rd_ptr)
    else $error("beat_fifo: write while full");

  a_head_hold: assert property (@(posedge clk) disable iff (reset)
    out.valid && !out.ready |=> out.valid && $stable(out.lanes) && $stable(out.op))
    else $error("beat_fifo: head beat changed under back-pressure");

endmodule

//--- src/sigmoid_lut.sv
`timescale 1ns/1ps

module sigmoid_lut import act_pkg::*; (
  act_stream_if.tap        beat,
  output sig_t [LANES-1:0] sig
);

  sig_t table_mem [LUT_SIZE];

  // rounded 256 * sigmoid(v / 16) for a signed q4.4 code v
  function automatic sig_t sig_code(input int v);
    real x;
    real s;
    x = real'(v) / (2.0 ** FRAC_W);
    s = 1.0 / (1.0 + $exp(-x));
    return sig_t'($rtoi(s * (2.0 ** SIG_FRAC) + 0.5));
  endfunction

  // ##########################################################
  // table, indexed by the raw two's complement bits
  // ##########################################################

  for (genvar k = 0; k < LUT_SIZE; k++) begin : g_table
    assign table_mem[k] = sig_code((k >= LUT_SIZE / 2) ? k - LUT_SIZE : k);
  end

  // non-decreasing when walked in signed order, -128 up to 127
  always_comb begin
    for (int p = 0; p < LUT_SIZE - 1; p++) begin
      if (table_mem[DATA_W'(p + LUT_SIZE / 2)] >
          table_mem[DATA_W'(p + 1 + LUT_SIZE / 2)]) begin
        $error("sigmoid_lut: table drops at input %0d", p - LUT_SIZE / 2);
      end
    end
  end

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    assign sig[i] = table_mem[$unsigned(beat.lanes[i])];  // bits as address
  end

endmodule

//--- src/linear_path.sv
`timescale 1ns/1ps

module linear_path import act_pkg::*; (
  act_stream_if.tap         beat,
  output lane_t [LANES-1:0] lin
);

  logic use_leaky;

  assign use_leaky = (beat.op == OP_LEAKY);  // relu for every other opcode

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    lane_t x;
    lane_t relu_v;
    lane_t leaky_v;

    assign x = beat.lanes[i];

    // clamp negatives to zero
    assign relu_v = x[DATA_W-1] ? '0 : x;

    // arithmetic shift floors toward minus infinity, -1 stays -1
    assign leaky_v = x[DATA_W-1] ? (x >>> LEAKY_SHIFT) : x;

    assign lin[i] = use_leaky ? leaky_v : relu_v;
  end

endmodule

//--- src/act_combine.sv
`timescale 1ns/1ps

module act_combine import act_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  act_stream_if.snk         beat,
  input  sig_t [LANES-1:0]  sig,
  input  lane_t [LANES-1:0] lin,
  output lane_t [LANES-1:0] out_lanes,
  output logic              out_valid,
  input  logic              out_ready
);

  lane_t [LANES-1:0] res;  // selected result, before the slice
  logic              load;

  // ##########################################################
  // per lane arithmetic and opcode select
  // ##########################################################

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    lane_t                    x;
    logic signed [SIG_W:0]    sig_s;
    logic signed [PROD_W-1:0] prod;
    logic signed [PROD_W-1:0] rnd;
    logic [SIG_W:0]           sig_sum;
    lane_t                    silu_v;
    lane_t                    sig_v;

    assign x     = beat.lanes[i];
    assign sig_s = {1'b0, sig[i]};  // code is never negative
    assign prod  = x * sig_s;  // q4.4 times q1.8 gives q.12

    // round half up, back to q4.4
    assign rnd = (prod + PROD_W'(SILU_RND)) >>> SIG_FRAC;

    assign silu_v = (rnd > PROD_W'(LANE_MAX)) ? lane_t'(LANE_MAX) :
                    (rnd < PROD_W'(LANE_MIN)) ? lane_t'(LANE_MIN) :
                    rnd[DATA_W-1:0];

    // 0..256 maps onto 0..16
    assign sig_sum = (SIG_W + 1)'(sig[i]) + (SIG_W + 1)'(SIG_RND);
    assign sig_v   = lane_t'(sig_sum >> SIG_SHIFT);

    assign res[i] = (beat.op == OP_SILU)    ? silu_v :
                    (beat.op == OP_SIGMOID) ? sig_v  :
                    lin[i];  // relu and leaky come ready from the linear path
  end

  // ##########################################################
  // output register slice
  // ##########################################################

  assign beat.ready = !out_valid || out_ready;  // empty or draining this cycle
  assign load       = beat.valid && beat.ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (beat.ready) begin
      out_valid <= beat.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      out_lanes <= res;
    end
  end

  a_out_hold: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_lanes))
    else $error("act_combine: data_out changed under back-pressure");

endmodule

//--- src/fixed_activation.sv
`timescale 1ns/1ps

module fixed_activation import act_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  lane_t [LANES-1:0] data_in,
  input  act_op_e           data_in_op,
  input  logic              data_in_valid,
  output logic              data_in_ready,
  output lane_t [LANES-1:0] data_out,
  output logic              data_out_valid,
  input  logic              data_out_ready
);

  // ##########################################################
  // fifo head shared by both paths and the combiner
  // ##########################################################

  act_stream_if fifo_beat ();

  sig_t [LANES-1:0]  sig;  // q1.8 codes from the table
  lane_t [LANES-1:0] lin;  // relu or leaky, already chosen by op

  beat_fifo u_fifo (
    .clk      (clk),
    .reset    (reset),
    .in_lanes (data_in),
    .in_op    (data_in_op),
    .in_valid (data_in_valid),
    .in_ready (data_in_ready),
    .out      (fifo_beat.src)
  );

  // ##########################################################
  // parallel paths, both combinational
  // ##########################################################

  sigmoid_lut u_sigmoid (
    .beat (fifo_beat.tap),
    .sig  (sig)
  );

  linear_path u_linear (
    .beat (fifo_beat.tap),
    .lin  (lin)
  );

  // select and register, pops the fifo
  act_combine u_combine (
    .clk       (clk),
    .reset     (reset),
    .beat      (fifo_beat.snk),
    .sig       (sig),
    .lin       (lin),
    .out_lanes (data_out),
    .out_valid (data_out_valid),
    .out_ready (data_out_ready)
  );

endmodule

//--- testbench/act_ref_model.svh
`ifndef ACT_REF_MODEL_SVH
`define ACT_REF_MODEL_SVH

typedef lane_t [LANES-1:0] beat_t;

// 32-bit xorshift, shifts 13, 17, 5
function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] v;
  v = s;
  v = v ^ (v << 13);
  v = v ^ (v >> 17);
  v = v ^ (v << 5);
  return v;
endfunction

// 256 * sigmoid(v / 16), rounded to nearest
function automatic int sigmoid_code(input int v);
  real s;
  s = 1.0 / (1.0 + $exp(-real'(v) / 16.0));
  return $rtoi($floor(s * 256.0 + 0.5));
endfunction

function automatic lane_t expected_lane(input lane_t x, input act_op_e op);
  int xi;
  int r;
  xi = int'(x);  // sign extended q4.4
  case (op)
    OP_SILU: begin
      r = (xi * sigmoid_code(xi) + 128) >>> 8;
      if (r > 127) begin
        r = 127;
      end else if (r < -128) begin
        r = -128;
      end
    end
    OP_SIGMOID: r = (sigmoid_code(xi) + 8) >>> 4;  // 0..16
    OP_RELU:    r = (xi < 0) ? 0 : xi;
    default:    r = (xi < 0) ? (xi >>> 3) : xi;  // floor of x / 8
  endcase
  return lane_t'(r);
endfunction

function automatic beat_t expected_beat(input beat_t lanes, input act_op_e op);
  beat_t b;
  for (int i = 0; i < LANES; i++) begin
    b[i] = expected_lane(lanes[i], op);
  end
  return b;
endfunction

`endif

//--- testbench/tb_fixed_activation.sv
`timescale 1ns/1ps

module tb_fixed_activation import act_pkg::*; ();

  `include "act_ref_model.svh"

  localparam int WAIT_LIMIT = 200;  // cycles per wait loop

  typedef enum logic [1:0] {RDY_RANDOM, RDY_HIGH, RDY_LOW} rdy_mode_e;

  logic    clk = 1'b0;
  logic    reset = 1'b1;
  beat_t   data_in = '0;
  act_op_e data_in_op = OP_SILU;
  logic    data_in_valid = 1'b0;
  logic    data_in_ready;
  beat_t   data_out;
  logic    data_out_valid;
  logic    data_out_ready = 1'b0;

  logic [31:0] rng_state = 32'hcbef3e21;
  rdy_mode_e   rdy_mode = RDY_RANDOM;

  beat_t exp_q[$];
  beat_t exp_head = '0;  // queue head as of the last edge
  int    exp_count = 0;
  beat_t held_out = '0;
  int    in_total = 0;
  int    out_total = 0;
  int    cycle = 0;
  int    accept_cycle = 0;
  int    fill_base = 0;
  logic  fill_on = 1'b0;
  logic  lat_on = 1'b0;

  always #2 clk = ~clk;

  fixed_activation UUT (
    .clk            (clk),
    .reset          (reset),
    .data_in        (data_in),
    .data_in_op     (data_in_op),
    .data_in_valid  (data_in_valid),
    .data_in_ready  (data_in_ready),
    .data_out       (data_out),
    .data_out_valid (data_out_valid),
    .data_out_ready (data_out_ready)
  );

  // ##########################################################
  // scoreboard
  // ##########################################################

  always @(posedge clk) begin
    if (reset) begin
      exp_q.delete();
      in_total  <= 0;
      out_total <= 0;
    end else begin
      if (data_out_valid && data_out_ready) begin
        out_total <= out_total + 1;
        if (exp_q.size() != 0) begin
          void'(exp_q.pop_front());
        end
      end
      if (data_in_valid && data_in_ready) begin
        exp_q.push_back(expected_beat(data_in, data_in_op));
        in_total     <= in_total + 1;
        accept_cycle <= cycle;
      end
    end
    exp_head  <= (exp_q.size() != 0) ? exp_q[0] : '0;
    exp_count <= exp_q.size();
    held_out  <= data_out;
    cycle     <= cycle + 1;
  end

  a_out_value: assert property (@(posedge clk) disable iff (reset)
    data_out_valid && data_out_ready |-> data_out == exp_head)
    else fail_run($sformatf("CHECK FAILED data_out got 0x%h expected 0x%h",
                            data_out, exp_head));

  a_out_hold: assert property (@(posedge clk) disable iff (reset)
    data_out_valid && !data_out_ready |=> data_out == held_out)
    else fail_run($sformatf("CHECK FAILED data_out got 0x%h expected 0x%h",
                            data_out, held_out));

  a_reset_idle: assert property (@(posedge clk) reset |=> !data_out_valid)
    else fail_run($sformatf("CHECK FAILED data_out_valid got 0x%h expected 0x0",
                            data_out_valid));

  a_no_phantom: assert property (@(posedge clk) disable iff (reset)
    data_out_valid |-> exp_count > 0)
    else fail_run("output beat offered with no beat outstanding");

  a_full_count: assert property (@(posedge clk) disable iff (reset)
    fill_on && !data_in_ready |-> in_total - fill_base == FIFO_DEPTH + 1)
    else fail_run($sformatf("CHECK FAILED data_in_ready low after 0x%h beats, expected 0x%h",
                            in_total - fill_base, FIFO_DEPTH + 1));

  a_full_block: assert property (@(posedge clk) disable iff (reset)
    fill_on && in_total - fill_base > FIFO_DEPTH |-> !data_in_ready)
    else fail_run($sformatf("CHECK FAILED data_in_ready got 0x%h expected 0x0",
                            data_in_ready));

  a_latency: assert property (@(posedge clk) disable iff (reset)
    lat_on && data_out_valid && data_out_ready |-> cycle - accept_cycle == 2)
    else fail_run($sformatf("CHECK FAILED data_out_valid after 0x%h cycles, expected 0x2",
                            cycle - accept_cycle));

  // ##########################################################
  // stimulus helpers
  // ##########################################################

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1);
  endtask

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic beat_t random_beat();
    beat_t b;
    for (int i = 0; i < LANES; i++) begin
      b[i] = lane_t'(next_rand() >> 8);
    end
    return b;
  endfunction

  // one clock, then a fresh data_out_ready
  task automatic step();
    logic [31:0] r;
    @(posedge clk);
    r = next_rand();
    case (rdy_mode)
      RDY_HIGH: data_out_ready <= 1'b1;
      RDY_LOW:  data_out_ready <= 1'b0;
      default:  data_out_ready <= |r[1:0];  // high three cycles in four
    endcase
  endtask

  task automatic send_beat(input beat_t lanes, input act_op_e op);
    int waited;
    int gap;
    gap = int'(next_rand() % 3);
    repeat (gap) step();
    data_in       <= lanes;
    data_in_op    <= op;
    data_in_valid <= 1'b1;
    waited = 0;
    do begin
      step();
      waited++;
      if (!data_in_ready && waited > WAIT_LIMIT) begin
        fail_run("timeout waiting for data_in_ready");
      end
    end while (!data_in_ready);
    data_in_valid <= 1'b0;
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    do begin
      step();
      waited++;
      if (waited > WAIT_LIMIT) begin
        fail_run("timeout while draining the outstanding beats");
      end
    end while (out_total != in_total || data_out_valid);
  endtask

  // hold the output, push until the input side blocks, then release
  task automatic fill_until_blocked();
    int waited;
    rdy_mode = RDY_LOW;
    step();
    fill_base     <= in_total;
    fill_on       <= 1'b1;
    data_in       <= random_beat();
    data_in_op    <= act_op_e'(next_rand() >> 30);
    data_in_valid <= 1'b1;
    waited = 0;
    do begin
      step();
      waited++;
      if (waited > WAIT_LIMIT) begin
        fail_run("timeout waiting for data_in_ready to drop");
      end
      if (data_in_ready) begin
        data_in    <= random_beat();
        data_in_op <= act_op_e'(next_rand() >> 30);
      end
    end while (data_in_ready);
    step();
    fill_on <= 1'b0;
    rdy_mode = RDY_HIGH;
    waited = 0;
    do begin
      step();
      waited++;
      if (!data_in_ready && waited > WAIT_LIMIT) begin
        fail_run("timeout waiting for the held beat to enter");
      end
    end while (!data_in_ready);
    data_in_valid <= 1'b0;
    wait_drained();
  endtask

  // ##########################################################
  // test sequence
  // ##########################################################

  initial begin
    beat_t lanes;
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    // every input code under every opcode on lane 0
    for (int n = 0; n < 4 * LUT_SIZE; n++) begin
      lanes    = random_beat();
      lanes[0] = lane_t'(n % LUT_SIZE);
      send_beat(lanes, act_op_e'(n / LUT_SIZE));
    end
    for (int n = 0; n < 400; n++) begin
      send_beat(random_beat(), act_op_e'(next_rand() >> 30));
    end
    wait_drained();

    fill_until_blocked();

    rdy_mode = RDY_HIGH;
    for (int n = 0; n < 8; n++) begin
      lat_on <= 1'b1;
      send_beat(random_beat(), act_op_e'(n % 4));
      wait_drained();
      lat_on <= 1'b0;
    end

    step();
    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- compile.f
+incdir+testbench
src/act_pkg.sv
src/act_stream_if.sv
src/beat_fifo.sv
src/sigmoid_lut.sv
src/linear_path.sv
src/act_combine.sv
src/fixed_activation.sv
testbench/tb_fixed_activation.sv

//--- run_sim.sh
#!/bin/sh
# build with verilator, run, and decide on the pass line in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal \
  --top-module tb_fixed_activation \
  -f compile.f -o sim_fixed_activation
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/sim_fixed_activation 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1
